//--- lanes_pkg.sv
/* Shared widths, limits and packed bus structs for the read lane bundle */
package lanes_pkg;

    // --------------------
    // Sizes and limits
    // --------------------
    localparam int NUM_LANES        = 4;
    localparam int LANE_ID_W        = $clog2(NUM_LANES);
    localparam int ADDR_W           = 16;
    localparam int DATA_W           = 32;
    localparam int COUNT_W          = 8;
    // Wide enough for the full bundle total
    localparam int SUM_W            = DATA_W + COUNT_W + 2;
    localparam int LANE_OUTSTANDING = 4;
    localparam int OUTSTANDING_W    = $clog2(LANE_OUTSTANDING + 1);
    localparam int MEM_CREDITS      = 8;
    localparam int CREDIT_W         = $clog2(MEM_CREDITS + 1);

    // --------------------
    // Types
    // --------------------
    typedef logic [LANE_ID_W-1:0] lane_id_t;

    // Payload stored in each lane response FIFO
    typedef logic [DATA_W-1:0] lane_data_t;

    typedef struct packed {
        logic               valid;
        logic [ADDR_W-1:0]  base_addr;
        logic [COUNT_W-1:0] count;
    } descriptor_t;

    typedef struct packed {
        logic              valid;
        lane_id_t          lane_id;
        logic [ADDR_W-1:0] addr;
    } mem_request_t;

    // Lane id comes back unchanged from the request
    typedef struct packed {
        logic       valid;
        lane_id_t   lane_id;
        lane_data_t data;
    } mem_response_t;

    typedef struct packed {
        logic             valid;
        logic [SUM_W-1:0] sum;
    } result_t;

endpackage

//--- sync_fifo.sv
/* Synchronous circular-buffer FIFO with a type parameter for its entry */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 4
) (
    input  logic   ap_clk,
    input  logic   areset_lanes,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t pop_data,
    output logic   empty,
    output logic   full
);

    // DEPTH must be a power of two so the pointers wrap on their own
    entry_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     occupancy;
    logic                       do_push;
    logic                       do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (occupancy == '0);
    assign full     = (occupancy == ($clog2(DEPTH) + 1)'(DEPTH));
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // The reader must check empty first
    a_no_pop_empty: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        pop |-> !empty);

endmodule

//--- lane_engine.sv
/* Single read lane: interleaved address generation, in-flight tracking
   and accumulation of the returned words */
`timescale 1ns/1ps

module lane_engine #(
    parameter int LANE_INDEX = 0
) (
    input  logic                          ap_clk,
    input  logic                          areset_lanes,
    input  logic                          start,
    input  logic [lanes_pkg::ADDR_W-1:0]  base_addr,
    input  logic [lanes_pkg::COUNT_W-1:0] count,
    output logic                          req_valid,
    output logic [lanes_pkg::ADDR_W-1:0]  req_addr,
    input  logic                          grant,
    input  logic                          rsp_empty,
    input  lanes_pkg::lane_data_t         rsp_data,
    output logic                          rsp_pop,
    output logic                          lane_done,
    output logic [lanes_pkg::SUM_W-1:0]   lane_sum
);

    logic                                active;
    logic [lanes_pkg::COUNT_W-1:0]       issued;
    logic [lanes_pkg::COUNT_W-1:0]       received;
    logic [lanes_pkg::OUTSTANDING_W-1:0] inflight;
    logic [lanes_pkg::ADDR_W-1:0]        next_addr;

    // Cap on in-flight reads keeps the response FIFO from overflowing
    assign req_valid = active && (issued != count) &&
                       (inflight < lanes_pkg::OUTSTANDING_W'(lanes_pkg::LANE_OUTSTANDING));
    assign req_addr  = next_addr;
    assign rsp_pop   = !rsp_empty;

    // --------------------
    // Control state
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            active    <= 1'b0;
            issued    <= '0;
            received  <= '0;
            lane_done <= 1'b0;
        end else if (start) begin
            active    <= 1'b1;
            issued    <= '0;
            received  <= '0;
            lane_done <= 1'b0;
        end else begin
            if (grant) begin
                issued <= issued + 1'b1;
            end
            if (rsp_pop) begin
                received <= received + 1'b1;
            end
            if (active && (received == count)) begin
                active    <= 1'b0;
                lane_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            inflight <= '0;
        end else begin
            case ({grant, rsp_pop})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // --------------------
    // Address and sum
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (start) begin
            next_addr <= base_addr + lanes_pkg::ADDR_W'(LANE_INDEX);
            lane_sum  <= '0;
        end else begin
            if (grant) begin
                next_addr <= next_addr + lanes_pkg::ADDR_W'(lanes_pkg::NUM_LANES);
            end
            if (rsp_pop) begin
                lane_sum <= lane_sum + lanes_pkg::SUM_W'(rsp_data);
            end
        end
    end

    a_inflight_cap: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        inflight <= lanes_pkg::OUTSTANDING_W'(lanes_pkg::LANE_OUTSTANDING));

    // A routed response always belongs to a read this lane issued
    a_pop_has_read: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        rsp_pop |-> (inflight != '0));

endmodule

//--- request_arbiter.sv
/* Round-robin N-to-1 memory request arbiter with credit counter and
   registered request output */
`timescale 1ns/1ps

module request_arbiter (
    input  logic                            ap_clk,
    input  logic                            areset_lanes,
    input  logic [lanes_pkg::NUM_LANES-1:0] req_valid,
    input  logic [lanes_pkg::ADDR_W-1:0]    req_addr [lanes_pkg::NUM_LANES],
    output logic [lanes_pkg::NUM_LANES-1:0] grant,
    input  logic                            credit_return,
    output lanes_pkg::mem_request_t         request_memory_out
);

    lanes_pkg::lane_id_t            rr_ptr;
    lanes_pkg::lane_id_t            scan_idx;
    lanes_pkg::lane_id_t            winner;
    logic                           found;
    logic                           credit_ok;
    logic [lanes_pkg::CREDIT_W-1:0] credits;

    assign credit_ok = (credits != '0);

    // --------------------
    // Round-robin pick
    // --------------------
    always_comb begin
        found    = 1'b0;
        winner   = '0;
        scan_idx = '0;
        // Scan starts at the lane after the last winner
        for (int k = 0; k < lanes_pkg::NUM_LANES; k++) begin
            scan_idx = lanes_pkg::lane_id_t'((int'(rr_ptr) + k) % lanes_pkg::NUM_LANES);
            if (!found && req_valid[scan_idx]) begin
                found  = 1'b1;
                winner = scan_idx;
            end
        end
        grant = '0;
        if (found && credit_ok) begin
            grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            rr_ptr <= '0;
        end else if (|grant) begin
            rr_ptr <= lanes_pkg::lane_id_t'((int'(winner) + 1) % lanes_pkg::NUM_LANES);
        end
    end

    // --------------------
    // Credits
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            credits <= lanes_pkg::CREDIT_W'(lanes_pkg::MEM_CREDITS);
        end else begin
            case ({|grant, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Output register, payload held until the next grant
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            request_memory_out.valid <= 1'b0;
        end else begin
            request_memory_out.valid <= |grant;
        end
        if (|grant) begin
            request_memory_out.lane_id <= winner;
            request_memory_out.addr    <= req_addr[winner];
        end
    end

    a_grant_onehot: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        $onehot0(grant));

    // Memory must not return more credits than it handed out
    a_credit_max: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        credits <= lanes_pkg::CREDIT_W'(lanes_pkg::MEM_CREDITS));

endmodule

//--- response_router.sv
/* 1-to-N memory response router with one response FIFO per lane */
`timescale 1ns/1ps

module response_router (
    input  logic                            ap_clk,
    input  logic                            areset_lanes,
    input  lanes_pkg::mem_response_t        response_memory_in,
    input  logic [lanes_pkg::NUM_LANES-1:0] rsp_pop,
    output logic [lanes_pkg::NUM_LANES-1:0] rsp_empty,
    output lanes_pkg::lane_data_t           rsp_data [lanes_pkg::NUM_LANES]
);

    lanes_pkg::mem_response_t        rsp_reg;
    logic [lanes_pkg::NUM_LANES-1:0] push;
    logic [lanes_pkg::NUM_LANES-1:0] fifo_full;

    // Input register, only valid is cleared
    always_ff @(posedge ap_clk) begin
        rsp_reg <= response_memory_in;
        if (areset_lanes) begin
            rsp_reg.valid <= 1'b0;
        end
    end

    // --------------------
    // Lane id decode
    // --------------------
    for (genvar i = 0; i < lanes_pkg::NUM_LANES; i++) begin : gen_lane_fifo
        assign push[i] = rsp_reg.valid && (rsp_reg.lane_id == lanes_pkg::lane_id_t'(i));

        sync_fifo #(
            .entry_t (lanes_pkg::lane_data_t),
            .DEPTH   (lanes_pkg::LANE_OUTSTANDING)
        ) u_rsp_fifo (
            .ap_clk       (ap_clk),
            .areset_lanes (areset_lanes),
            .push         (push[i]),
            .push_data    (rsp_reg.data),
            .pop          (rsp_pop[i]),
            .pop_data     (rsp_data[i]),
            .empty        (rsp_empty[i]),
            .full         (fifo_full[i])
        );

        // Holds as long as each lane caps its in-flight reads
        a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_lanes)
            push[i] |-> !fifo_full[i]);
    end

endmodule

//--- bundle_control.sv
/* Descriptor register, idle/busy FSM, lane done collection and result */
`timescale 1ns/1ps

module bundle_control (
    input  logic                            ap_clk,
    input  logic                            areset_lanes,
    input  lanes_pkg::descriptor_t          descriptor_in,
    input  logic [lanes_pkg::NUM_LANES-1:0] lane_done,
    input  logic [lanes_pkg::SUM_W-1:0]     lane_sum [lanes_pkg::NUM_LANES],
    output logic                            start,
    output logic [lanes_pkg::ADDR_W-1:0]    base_addr,
    output logic [lanes_pkg::COUNT_W-1:0]   count,
    output lanes_pkg::result_t              result_out,
    output logic                            idle
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_FINISH
    } state_t;

    state_t                     state;
    logic                       accept;
    logic                       all_done;
    logic [lanes_pkg::SUM_W-1:0] total_sum;

    assign idle   = (state == ST_IDLE);
    assign accept = idle && descriptor_in.valid;
    // Lane done flags from the last run are stale while start is high
    assign all_done = (state == ST_BUSY) && !start && (&lane_done);

    always_comb begin
        total_sum = '0;
        for (int k = 0; k < lanes_pkg::NUM_LANES; k++) begin
            total_sum = total_sum + lane_sum[k];
        end
    end

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            state <= ST_IDLE;
            start <= 1'b0;
        end else begin
            start <= accept;
            case (state)
                ST_IDLE:   if (accept) state <= ST_BUSY;
                ST_BUSY:   if (all_done) state <= ST_FINISH;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            base_addr <= descriptor_in.base_addr;
            count     <= descriptor_in.count;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            result_out.valid <= 1'b0;
        end else begin
            result_out.valid <= all_done;
        end
        if (all_done) begin
            result_out.sum <= total_sum;
        end
    end

endmodule

//--- bundle_lanes.sv
/* Top level of the read lane bundle: control, lanes, request arbiter
   and response router */
`timescale 1ns/1ps

module bundle_lanes (
    input  logic                     ap_clk,
    input  logic                     areset_lanes,
    input  lanes_pkg::descriptor_t   descriptor_in,
    output lanes_pkg::mem_request_t  request_memory_out,
    input  logic                     credit_return,
    input  lanes_pkg::mem_response_t response_memory_in,
    output lanes_pkg::result_t       result_out,
    output logic                     idle
);

    // --------------------
    // Control to lanes
    // --------------------
    logic                          start;
    logic [lanes_pkg::ADDR_W-1:0]  base_addr;
    logic [lanes_pkg::COUNT_W-1:0] count;

    logic [lanes_pkg::NUM_LANES-1:0] lane_done;
    logic [lanes_pkg::SUM_W-1:0]     lane_sum [lanes_pkg::NUM_LANES];

    // --------------------
    // Lanes to arbiter
    // --------------------
    logic [lanes_pkg::NUM_LANES-1:0] req_valid;
    logic [lanes_pkg::ADDR_W-1:0]    req_addr [lanes_pkg::NUM_LANES];
    logic [lanes_pkg::NUM_LANES-1:0] grant;

    // Router to lanes
    logic [lanes_pkg::NUM_LANES-1:0] rsp_pop;
    logic [lanes_pkg::NUM_LANES-1:0] rsp_empty;
    lanes_pkg::lane_data_t           rsp_data [lanes_pkg::NUM_LANES];

    bundle_control u_control (
        .ap_clk        (ap_clk),
        .areset_lanes  (areset_lanes),
        .descriptor_in (descriptor_in),
        .lane_done     (lane_done),
        .lane_sum      (lane_sum),
        .start         (start),
        .base_addr     (base_addr),
        .count         (count),
        .result_out    (result_out),
        .idle          (idle)
    );

    for (genvar i = 0; i < lanes_pkg::NUM_LANES; i++) begin : gen_lane
        lane_engine #(
            .LANE_INDEX (i)
        ) u_lane (
            .ap_clk       (ap_clk),
            .areset_lanes (areset_lanes),
            .start        (start),
            .base_addr    (base_addr),
            .count        (count),
            .req_valid    (req_valid[i]),
            .req_addr     (req_addr[i]),
            .grant        (grant[i]),
            .rsp_empty    (rsp_empty[i]),
            .rsp_data     (rsp_data[i]),
            .rsp_pop      (rsp_pop[i]),
            .lane_done    (lane_done[i]),
            .lane_sum     (lane_sum[i])
        );
    end

    request_arbiter u_arbiter (
        .ap_clk             (ap_clk),
        .areset_lanes       (areset_lanes),
        .req_valid          (req_valid),
        .req_addr           (req_addr),
        .grant              (grant),
        .credit_return      (credit_return),
        .request_memory_out (request_memory_out)
    );

    response_router u_router (
        .ap_clk             (ap_clk),
        .areset_lanes       (areset_lanes),
        .response_memory_in (response_memory_in),
        .rsp_pop            (rsp_pop),
        .rsp_empty          (rsp_empty),
        .rsp_data           (rsp_data)
    );

endmodule

//--- tb_bundle_lanes.sv
/* Testbench for the read lane bundle: clock, reset, memory model with
   credits, random descriptors, request and result checks */
`timescale 1ns/1ps

module tb_bundle_lanes;

    localparam int NUM_TESTS = 20;
    localparam int TIMEOUT   = 5000;
    localparam int MEM_WORDS = 1 << lanes_pkg::ADDR_W;

    logic                     ap_clk = 1'b0;
    logic                     areset_lanes = 1'b1;
    lanes_pkg::descriptor_t   descriptor_in = '0;
    lanes_pkg::mem_request_t  request_memory_out;
    logic                     credit_return = 1'b0;
    lanes_pkg::mem_response_t response_memory_in = '0;
    lanes_pkg::result_t       result_out;
    logic                     idle;

    integer seed = 12;
    int     errors = 0;
    int     tests_run = 0;
    logic   timed_out = 1'b0;

    // --------------------
    // Memory model state
    // --------------------
    lanes_pkg::lane_data_t        mem [MEM_WORDS];
    lanes_pkg::lane_id_t          q_lane [$];
    logic [lanes_pkg::ADDR_W-1:0] q_addr [$];
    int                           q_due [$];
    int                           cycle = 0;
    int                           outstanding = 0;
    logic                         slow_mode = 1'b0;

    // Expected request stream of the running descriptor
    logic [lanes_pkg::ADDR_W-1:0]  cur_base = '0;
    logic [lanes_pkg::COUNT_W-1:0] cur_count = '0;
    int                            lane_k [lanes_pkg::NUM_LANES];
    int                            result_pulses = 0;

    bundle_lanes bundle_lanes_i (
        .ap_clk             (ap_clk),
        .areset_lanes       (areset_lanes),
        .descriptor_in      (descriptor_in),
        .request_memory_out (request_memory_out),
        .credit_return      (credit_return),
        .response_memory_in (response_memory_in),
        .result_out         (result_out),
        .idle               (idle)
    );

    always #4 ap_clk = ~ap_clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Memory answers in order, each after its own random delay
    always @(negedge ap_clk) begin : memory_model
        logic [lanes_pkg::ADDR_W-1:0] exp_addr;
        int                           lane;
        if (!areset_lanes) begin
            if (request_memory_out.valid) begin
                lane     = int'(request_memory_out.lane_id);
                exp_addr = cur_base + lanes_pkg::ADDR_W'(lane)
                         + lanes_pkg::ADDR_W'(lane_k[lane] * lanes_pkg::NUM_LANES);
                if (lane_k[lane] >= int'(cur_count)) begin
                    $display("Error at %0t: lane %0d requested more than %0d words",
                             $time, lane, cur_count);
                    errors++;
                end
                check_value("request_memory_out.addr", 64'(exp_addr),
                            64'(request_memory_out.addr));
                lane_k[lane]++;
                q_lane.push_back(request_memory_out.lane_id);
                q_addr.push_back(request_memory_out.addr);
                // Slow runs hold responses long enough to run out of credits
                q_due.push_back(cycle + 1 + int'({$random(seed)} % 6) + (slow_mode ? 12 : 0));
                outstanding++;
                if (outstanding > lanes_pkg::MEM_CREDITS) begin
                    $display("Error at %0t: %0d requests in flight, more than the credits",
                             $time, outstanding);
                    errors++;
                end
            end
            response_memory_in = '0;
            credit_return      = 1'b0;
            if (q_due.size() > 0 && q_due[0] <= cycle) begin
                response_memory_in.valid   = 1'b1;
                response_memory_in.lane_id = q_lane.pop_front();
                response_memory_in.data    = mem[q_addr.pop_front()];
                void'(q_due.pop_front());
                credit_return = 1'b1;
                outstanding--;
            end
            if (result_out.valid) begin
                result_pulses++;
            end
            cycle++;
        end
    end

    task automatic wait_idle();
        int n = 0;
        while (!idle && n < TIMEOUT) begin
            @(negedge ap_clk);
            n++;
        end
        if (!idle) begin
            $display("Timeout: the bundle never returned to idle");
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic run_descriptor(input int t);
        logic [lanes_pkg::SUM_W-1:0]  exp_sum;
        logic [lanes_pkg::SUM_W-1:0]  got_sum;
        logic [lanes_pkg::ADDR_W-1:0] addr;
        int                           errors_before;
        int                           n;
        logic                         seen;
        errors_before = errors;
        wait_idle();
        if (timed_out) return;
        cur_base  = lanes_pkg::ADDR_W'($random(seed));
        cur_count = lanes_pkg::COUNT_W'({$random(seed)} % 32);
        slow_mode = (t % 4 == 3);
        foreach (lane_k[i]) lane_k[i] = 0;
        result_pulses = 0;
        // Reference total over every interleaved address
        exp_sum = '0;
        for (int i = 0; i < lanes_pkg::NUM_LANES; i++) begin
            for (int k = 0; k < int'(cur_count); k++) begin
                addr    = cur_base + lanes_pkg::ADDR_W'(i)
                        + lanes_pkg::ADDR_W'(k * lanes_pkg::NUM_LANES);
                exp_sum = exp_sum + lanes_pkg::SUM_W'(mem[addr]);
            end
        end
        descriptor_in.valid     = 1'b1;
        descriptor_in.base_addr = cur_base;
        descriptor_in.count     = cur_count;
        @(negedge ap_clk);
        // Junk descriptor while busy must leave the run untouched
        descriptor_in.base_addr = lanes_pkg::ADDR_W'($random(seed));
        descriptor_in.count     = lanes_pkg::COUNT_W'($random(seed));
        for (int j = 0; j < 2; j++) begin
            check_value("idle", 64'(0), 64'(idle));
            @(negedge ap_clk);
        end
        descriptor_in = '0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            if (result_out.valid) begin
                seen    = 1'b1;
                got_sum = result_out.sum;
            end else begin
                check_value("idle", 64'(0), 64'(idle));
                @(negedge ap_clk);
                n++;
            end
        end
        if (!seen) begin
            $display("Timeout: no result for descriptor %0d", t);
            timed_out = 1'b1;
            errors++;
            return;
        end
        @(negedge ap_clk);
        check_value("idle", 64'(1), 64'(idle));
        @(negedge ap_clk);
        check_value("result_out.valid pulses", 64'(1), 64'(result_pulses));
        check_value("result_out.sum", 64'(exp_sum), 64'(got_sum));
        for (int i = 0; i < lanes_pkg::NUM_LANES; i++) begin
            check_value("lane request count", 64'(cur_count), 64'(lane_k[i]));
        end
        tests_run++;
        $display("Test %0d: base %h count %0d %s sum %h %s", t, cur_base, cur_count,
                 slow_mode ? "slow" : "fast", got_sum,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = $random(seed);
        end
        repeat (5) @(negedge ap_clk);
        areset_lanes = 1'b0;
        @(negedge ap_clk);
        check_value("idle", 64'(1), 64'(idle));
        check_value("request_memory_out.valid", 64'(0), 64'(request_memory_out.valid));
        check_value("result_out.valid", 64'(0), 64'(result_out.valid));
        tests_run++;
        $display("Test reset: %s", (errors == 0) ? "ok" : "mismatch");
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_descriptor(t);
        end
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
lanes_pkg.sv
sync_fifo.sv
lane_engine.sv
request_arbiter.sv
response_router.sv
bundle_control.sv
bundle_lanes.sv
tb_bundle_lanes.sv

//--- Makefile
# Verilator lint, simulation and cleanup for the read lane bundle
TOP := tb_bundle_lanes

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
